// File: logic/rv_slice_params.svh
/* rv32i decode/execute slice
   width and register file sizing macros */
`ifndef RV_SLICE_PARAMS_SVH
`define RV_SLICE_PARAMS_SVH

// data path and pc width
`define XLEN 32

// architectural integer registers
`define NUM_REGS 32

// index width into the register file
`define REG_AW 5

`endif

// File: logic/rv_slice_pkg.sv
/* rv32i slice shared types
   instruction format views, opcode and alu encodings, stage payloads */
`include "rv_slice_params.svh"

package rv_slice_pkg;

	typedef enum logic [6:0] {
		opc_load   = 7'b0000011,
		opc_imm    = 7'b0010011,
		opc_auipc  = 7'b0010111,
		opc_store  = 7'b0100011,
		opc_reg    = 7'b0110011,
		opc_lui    = 7'b0110111,
		opc_branch = 7'b1100011,
		opc_jalr   = 7'b1100111,
		opc_jal    = 7'b1101111,
		opc_system = 7'b1110011
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
		alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
	} alu_op_e;

	typedef enum logic [2:0] {
		cmp_none, cmp_eq, cmp_ne, cmp_lt, cmp_ge, cmp_ltu, cmp_geu
	} cmp_op_e;

	// port b source
	localparam logic [1:0] portb_reg  = 2'd0;
	localparam logic [1:0] portb_imm  = 2'd1;
	localparam logic [1:0] portb_four = 2'd2;

	typedef struct packed {
		logic [6:0] funct7;
		logic [`REG_AW-1:0] rs2;
		logic [`REG_AW-1:0] rs1;
		logic [2:0] funct3;
		logic [`REG_AW-1:0] rd;
		opcode_e opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [`REG_AW-1:0] rs1;
		logic [2:0] funct3;
		logic [`REG_AW-1:0] rd;
		opcode_e opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [`REG_AW-1:0] rs2;
		logic [`REG_AW-1:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		opcode_e opcode;
	} s_fmt_t;

	typedef struct packed {
		logic imm_12;
		logic [5:0] imm_10_5;
		logic [`REG_AW-1:0] rs2;
		logic [`REG_AW-1:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic imm_11;
		opcode_e opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [`REG_AW-1:0] rd;
		opcode_e opcode;
	} u_fmt_t;

	typedef struct packed {
		logic imm_20;
		logic [9:0] imm_10_1;
		logic imm_11;
		logic [7:0] imm_19_12;
		logic [`REG_AW-1:0] rd;
		opcode_e opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} instr_u;

	typedef struct packed {
		logic [`REG_AW-1:0] rs1;
		logic [`REG_AW-1:0] rs2;
		logic [`REG_AW-1:0] rd;
		logic reg_write;
		alu_op_e alu_op;
		cmp_op_e cmp_op;
		logic porta_sel;        // 1 selects pc
		logic [1:0] portb_sel;
		logic jump;             // jal or jalr
		logic jalr;
		logic ecall;
		logic ebreak;
		logic illegal;
	} ctrl_t;

	typedef struct packed {
		logic misaligned;
		logic ecall;
		logic ebreak;
		logic illegal;
	} exc_t;

	typedef struct packed {
		logic valid;
		logic [`XLEN-1:0] port_a;
		logic [`XLEN-1:0] port_b;
		alu_op_e alu_op;
		logic [`REG_AW-1:0] rd;
		logic reg_write;
		exc_t exc;
	} idex_t;

	typedef struct packed {
		logic valid;
		logic [`XLEN-1:0] target;
	} redirect_t;

	typedef struct packed {
		logic valid;
		logic [`REG_AW-1:0] rd;
		logic [`XLEN-1:0] data;
		logic we;
		exc_t exc;
	} wb_t;

endpackage

// File: logic/instr_decoder.sv
/* rv32i instruction decoder
   opcode/funct decode into control fields plus sign-extended immediate */
`include "rv_slice_params.svh"

module instr_decoder (
	input  rv_slice_pkg::instr_u instr_i,
	output rv_slice_pkg::ctrl_t  ctrl_o,
	output logic [`XLEN-1:0]     imm_o
);

	logic [6:0] funct7;
	logic [2:0] funct3;
	logic f7_base;
	logic f7_alt;

	assign funct7 = instr_i.r.funct7;
	assign funct3 = instr_i.r.funct3;
	assign f7_base = (funct7 == 7'b0000000);
	assign f7_alt = (funct7 == 7'b0100000);     // sub / sra

	function automatic rv_slice_pkg::alu_op_e alu_from_funct3(
		input logic [2:0] f3,
		input logic alt
	);
		case (f3)
			3'b000: return alt ? rv_slice_pkg::alu_sub : rv_slice_pkg::alu_add;
			3'b001: return rv_slice_pkg::alu_sll;
			3'b010: return rv_slice_pkg::alu_slt;
			3'b011: return rv_slice_pkg::alu_sltu;
			3'b100: return rv_slice_pkg::alu_xor;
			3'b101: return alt ? rv_slice_pkg::alu_sra : rv_slice_pkg::alu_srl;
			3'b110: return rv_slice_pkg::alu_or;
			default: return rv_slice_pkg::alu_and;
		endcase
	endfunction

	always_comb begin
		ctrl_o = '0;
		ctrl_o.rs1 = instr_i.r.rs1;
		ctrl_o.rs2 = instr_i.r.rs2;
		ctrl_o.rd = instr_i.r.rd;
		ctrl_o.alu_op = rv_slice_pkg::alu_add;
		ctrl_o.cmp_op = rv_slice_pkg::cmp_none;
		ctrl_o.portb_sel = rv_slice_pkg::portb_reg;
		imm_o = {{20{instr_i.i.imm_11_0[11]}}, instr_i.i.imm_11_0};

		case (instr_i.r.opcode)
			rv_slice_pkg::opc_lui: begin
				imm_o = {instr_i.u.imm_31_12, 12'b0};
				ctrl_o.reg_write = 1'b1;
				ctrl_o.alu_op = rv_slice_pkg::alu_pass_b;
				ctrl_o.portb_sel = rv_slice_pkg::portb_imm;
			end
			rv_slice_pkg::opc_auipc: begin
				imm_o = {instr_i.u.imm_31_12, 12'b0};
				ctrl_o.reg_write = 1'b1;
				ctrl_o.porta_sel = 1'b1;
				ctrl_o.portb_sel = rv_slice_pkg::portb_imm;
			end
			rv_slice_pkg::opc_jal: begin
				imm_o = {{11{instr_i.j.imm_20}}, instr_i.j.imm_20, instr_i.j.imm_19_12,
					instr_i.j.imm_11, instr_i.j.imm_10_1, 1'b0};
				ctrl_o.reg_write = 1'b1;
				ctrl_o.jump = 1'b1;
				ctrl_o.porta_sel = 1'b1;    // link = pc + 4
				ctrl_o.portb_sel = rv_slice_pkg::portb_four;
			end
			rv_slice_pkg::opc_jalr: begin
				ctrl_o.reg_write = 1'b1;
				ctrl_o.jump = 1'b1;
				ctrl_o.jalr = 1'b1;
				ctrl_o.porta_sel = 1'b1;
				ctrl_o.portb_sel = rv_slice_pkg::portb_four;
				ctrl_o.illegal = (instr_i.i.funct3 != 3'b000);
			end
			rv_slice_pkg::opc_branch: begin
				imm_o = {{19{instr_i.b.imm_12}}, instr_i.b.imm_12, instr_i.b.imm_11,
					instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};
				case (instr_i.b.funct3)
					3'b000: ctrl_o.cmp_op = rv_slice_pkg::cmp_eq;
					3'b001: ctrl_o.cmp_op = rv_slice_pkg::cmp_ne;
					3'b100: ctrl_o.cmp_op = rv_slice_pkg::cmp_lt;
					3'b101: ctrl_o.cmp_op = rv_slice_pkg::cmp_ge;
					3'b110: ctrl_o.cmp_op = rv_slice_pkg::cmp_ltu;
					3'b111: ctrl_o.cmp_op = rv_slice_pkg::cmp_geu;
					default: ctrl_o.illegal = 1'b1;
				endcase
			end
			rv_slice_pkg::opc_imm: begin
				ctrl_o.reg_write = 1'b1;
				ctrl_o.portb_sel = rv_slice_pkg::portb_imm;
				// shift immediates reuse the funct7 field of the r view
				ctrl_o.alu_op = alu_from_funct3(funct3, f7_alt && funct3 == 3'b101);
				if (funct3 == 3'b001)
					ctrl_o.illegal = !f7_base;
				else if (funct3 == 3'b101)
					ctrl_o.illegal = !(f7_base || f7_alt);
			end
			rv_slice_pkg::opc_reg: begin
				ctrl_o.reg_write = 1'b1;
				ctrl_o.alu_op = alu_from_funct3(funct3, f7_alt);
				ctrl_o.illegal = !(f7_base ||
					(f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
			end
			rv_slice_pkg::opc_system: begin
				if (instr_i.i.funct3 == 3'b000 && instr_i.i.rs1 == '0 &&
					instr_i.i.rd == '0 && instr_i.i.imm_11_0 == 12'd0)
					ctrl_o.ecall = 1'b1;
				else if (instr_i.i.funct3 == 3'b000 && instr_i.i.rs1 == '0 &&
					instr_i.i.rd == '0 && instr_i.i.imm_11_0 == 12'd1)
					ctrl_o.ebreak = 1'b1;
				else
					ctrl_o.illegal = 1'b1;  // csr space not supported
			end
			rv_slice_pkg::opc_store: begin
				imm_o = {{20{instr_i.s.imm_11_5[6]}}, instr_i.s.imm_11_5, instr_i.s.imm_4_0};
				ctrl_o.illegal = 1'b1;      // no memory stage
			end
			default: ctrl_o.illegal = 1'b1;     // loads, fence, unknown
		endcase

		if (ctrl_o.illegal)
			ctrl_o.reg_write = 1'b0;
	end

endmodule

// File: logic/register_file.sv
/* integer register file, x0 fixed at zero
   two async read ports with write-through from the write port */
`include "rv_slice_params.svh"

module register_file (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  logic [`REG_AW-1:0] raddr_a_i,
	input  logic [`REG_AW-1:0] raddr_b_i,
	output logic [`XLEN-1:0]   rdata_a_o,
	output logic [`XLEN-1:0]   rdata_b_o,
	input  logic [`REG_AW-1:0] waddr_i,
	input  logic [`XLEN-1:0]   wdata_i,
	input  logic               we_i
);

	logic [`XLEN-1:0] regs_q [`NUM_REGS];

	function automatic logic [`XLEN-1:0] read_port(input logic [`REG_AW-1:0] addr);
		if (addr == '0)
			return '0;
		if (we_i && addr == waddr_i)
			return wdata_i;         // same-cycle bypass
		return regs_q[addr];
	endfunction

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < `NUM_REGS; i++)
				regs_q[i] <= '0;
		end else if (we_i && waddr_i != '0) begin
			regs_q[waddr_i] <= wdata_i;
		end
	end

	always_comb begin
		rdata_a_o = read_port(raddr_a_i);
		rdata_b_o = read_port(raddr_b_i);
	end

endmodule

// File: logic/id_stage.sv
/* decode stage: forwarding, branch resolve and target calc
   registers operands into id/ex and the redirect output */
`include "rv_slice_params.svh"

module id_stage (
	input  logic                    clk_i,
	input  logic                    rst_n_i,
	input  logic                    valid_i,
	input  logic [`XLEN-1:0]        pc_i,
	input  rv_slice_pkg::ctrl_t     ctrl_i,
	input  logic [`XLEN-1:0]        imm_i,
	input  logic [`XLEN-1:0]        rdata_a_i,
	input  logic [`XLEN-1:0]        rdata_b_i,
	input  logic [`REG_AW-1:0]      fwd_rd_i,
	input  logic [`XLEN-1:0]        fwd_data_i,
	input  logic                    fwd_we_i,
	output rv_slice_pkg::idex_t     idex_o,
	output rv_slice_pkg::redirect_t redirect_o
);

	logic [`XLEN-1:0] rs1_val;
	logic [`XLEN-1:0] rs2_val;
	logic [`XLEN-1:0] jalr_sum;
	logic [`XLEN-1:0] target;
	logic [`XLEN-1:0] port_a;
	logic [`XLEN-1:0] port_b;
	logic take;
	logic redirect;
	logic reg_write;
	rv_slice_pkg::exc_t exc;

	logic idex_valid_q;
	logic redirect_valid_q;
	logic [`XLEN-1:0] port_a_q;
	logic [`XLEN-1:0] port_b_q;
	logic [`XLEN-1:0] target_q;
	rv_slice_pkg::alu_op_e alu_op_q;
	logic [`REG_AW-1:0] rd_q;
	logic reg_write_q;
	rv_slice_pkg::exc_t exc_q;

	function automatic logic [`XLEN-1:0] forward(
		input logic [`REG_AW-1:0] rs,
		input logic [`XLEN-1:0] rf_data
	);
		if (fwd_we_i && fwd_rd_i != '0 && fwd_rd_i == rs)
			return fwd_data_i;
		return rf_data;
	endfunction

	always_comb begin
		rs1_val = forward(ctrl_i.rs1, rdata_a_i);
		rs2_val = forward(ctrl_i.rs2, rdata_b_i);
	end

	always_comb begin
		case (ctrl_i.cmp_op)
			rv_slice_pkg::cmp_eq:  take = (rs1_val == rs2_val);
			rv_slice_pkg::cmp_ne:  take = (rs1_val != rs2_val);
			rv_slice_pkg::cmp_lt:  take = ($signed(rs1_val) < $signed(rs2_val));
			rv_slice_pkg::cmp_ge:  take = ($signed(rs1_val) >= $signed(rs2_val));
			rv_slice_pkg::cmp_ltu: take = (rs1_val < rs2_val);
			rv_slice_pkg::cmp_geu: take = (rs1_val >= rs2_val);
			default:               take = 1'b0;
		endcase
	end

	assign jalr_sum = rs1_val + imm_i;
	assign target = ctrl_i.jalr ? {jalr_sum[`XLEN-1:1], 1'b0} : pc_i + imm_i;
	assign redirect = ctrl_i.jump | take;

	assign exc = '{misaligned: redirect & target[1], ecall: ctrl_i.ecall,
		ebreak: ctrl_i.ebreak, illegal: ctrl_i.illegal};
	assign reg_write = ctrl_i.reg_write & ~(|exc) & (ctrl_i.rd != '0);

	assign port_a = ctrl_i.porta_sel ? pc_i : rs1_val;

	always_comb begin
		case (ctrl_i.portb_sel)
			rv_slice_pkg::portb_imm:  port_b = imm_i;
			rv_slice_pkg::portb_four: port_b = `XLEN'd4;
			default:                  port_b = rs2_val;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			idex_valid_q <= 1'b0;
			redirect_valid_q <= 1'b0;
		end else begin
			idex_valid_q <= valid_i;
			redirect_valid_q <= valid_i & redirect;
		end
	end

	always_ff @(posedge clk_i) begin
		if (valid_i) begin
			port_a_q <= port_a;
			port_b_q <= port_b;
			target_q <= target;
			alu_op_q <= ctrl_i.alu_op;
			rd_q <= ctrl_i.rd;
			reg_write_q <= reg_write;
			exc_q <= exc;
		end
	end

	assign idex_o = '{valid: idex_valid_q, port_a: port_a_q, port_b: port_b_q,
		alu_op: alu_op_q, rd: rd_q, reg_write: reg_write_q, exc: exc_q};
	assign redirect_o = '{valid: redirect_valid_q, target: target_q};

endmodule

// File: logic/ex_stage.sv
/* execute stage: alu on id/ex ports
   forwards result to decode and registers the write-back report */
`include "rv_slice_params.svh"

module ex_stage (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  rv_slice_pkg::idex_t idex_i,
	output logic [`REG_AW-1:0]  fwd_rd_o,
	output logic [`XLEN-1:0]    fwd_data_o,
	output logic                fwd_we_o,
	output rv_slice_pkg::wb_t   wb_o
);

	localparam int shamt_w = $clog2(`XLEN);

	logic [`XLEN-1:0] a;
	logic [`XLEN-1:0] b;
	logic [shamt_w-1:0] shamt;
	logic [`XLEN-1:0] result;

	logic wb_valid_q;
	logic [`REG_AW-1:0] wb_rd_q;
	logic [`XLEN-1:0] wb_data_q;
	logic wb_we_q;
	rv_slice_pkg::exc_t wb_exc_q;

	assign a = idex_i.port_a;
	assign b = idex_i.port_b;
	assign shamt = b[shamt_w-1:0];

	always_comb begin
		case (idex_i.alu_op)
			rv_slice_pkg::alu_add:    result = a + b;
			rv_slice_pkg::alu_sub:    result = a - b;
			rv_slice_pkg::alu_sll:    result = a << shamt;
			rv_slice_pkg::alu_slt:    result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			rv_slice_pkg::alu_sltu:   result = {{(`XLEN-1){1'b0}}, a < b};
			rv_slice_pkg::alu_xor:    result = a ^ b;
			rv_slice_pkg::alu_srl:    result = a >> shamt;
			rv_slice_pkg::alu_sra:    result = $signed(a) >>> shamt;
			rv_slice_pkg::alu_or:     result = a | b;
			rv_slice_pkg::alu_and:    result = a & b;
			rv_slice_pkg::alu_pass_b: result = b;       // lui
			default:                  result = '0;
		endcase
	end

	// result of the instruction now in ex
	assign fwd_rd_o = idex_i.rd;
	assign fwd_data_o = result;
	assign fwd_we_o = idex_i.valid & idex_i.reg_write;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			wb_valid_q <= 1'b0;
		else
			wb_valid_q <= idex_i.valid;
	end

	always_ff @(posedge clk_i) begin
		if (idex_i.valid) begin
			wb_rd_q <= idex_i.rd;
			wb_data_q <= result;
			wb_we_q <= idex_i.reg_write;
			wb_exc_q <= idex_i.exc;
		end
	end

	assign wb_o = '{valid: wb_valid_q, rd: wb_rd_q, data: wb_data_q,
		we: wb_we_q, exc: wb_exc_q};

endmodule

// File: logic/rv_slice_top.sv
/* rv32i decode/execute slice top
   decoder, register file, decode and execute stages */
`include "rv_slice_params.svh"

module rv_slice_top (
	input  logic                    clk_i,
	input  logic                    rst_n_i,
	input  logic                    instr_valid_i,
	input  rv_slice_pkg::instr_u    instr_i,
	input  logic [`XLEN-1:0]        pc_i,
	output rv_slice_pkg::redirect_t redirect_o,
	output rv_slice_pkg::wb_t       wb_o
);

	rv_slice_pkg::ctrl_t ctrl;
	rv_slice_pkg::idex_t idex;
	logic [`XLEN-1:0] imm;
	logic [`XLEN-1:0] rdata_a;
	logic [`XLEN-1:0] rdata_b;
	logic [`REG_AW-1:0] fwd_rd;
	logic [`XLEN-1:0] fwd_data;
	logic fwd_we;

	instr_decoder u_decoder (
		.instr_i (instr_i),
		.ctrl_o  (ctrl),
		.imm_o   (imm)
	);

	register_file u_regfile (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.raddr_a_i (ctrl.rs1),
		.raddr_b_i (ctrl.rs2),
		.rdata_a_o (rdata_a),
		.rdata_b_o (rdata_b),
		.waddr_i   (wb_o.rd),
		.wdata_i   (wb_o.data),
		.we_i      (wb_o.valid & wb_o.we)
	);

	id_stage u_id (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.valid_i    (instr_valid_i),
		.pc_i       (pc_i),
		.ctrl_i     (ctrl),
		.imm_i      (imm),
		.rdata_a_i  (rdata_a),
		.rdata_b_i  (rdata_b),
		.fwd_rd_i   (fwd_rd),
		.fwd_data_i (fwd_data),
		.fwd_we_i   (fwd_we),
		.idex_o     (idex),
		.redirect_o (redirect_o)
	);

	ex_stage u_ex (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.idex_i     (idex),
		.fwd_rd_o   (fwd_rd),
		.fwd_data_o (fwd_data),
		.fwd_we_o   (fwd_we),
		.wb_o       (wb_o)
	);

endmodule

// File: tests/rv_slice_top_sva.sv
/* assertions bound into the rv32i slice top
   reset state, valid latency and no write-back to x0 */
module rv_slice_top_sva (
	input logic                    clk_i,
	input logic                    rst_n_i,
	input logic                    instr_valid_i,
	input rv_slice_pkg::redirect_t redirect_i,
	input rv_slice_pkg::wb_t       wb_i
);

	timeunit 1ns;
	timeprecision 1ps;

	reset_clears_valids: assert property (@(posedge clk_i)
		!rst_n_i |-> !wb_i.valid && !redirect_i.valid)
		else $error("valid output set during reset");

	// two register stages from strobe to write-back
	wb_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_i.valid == $past(instr_valid_i, 2))
		else $error("write-back valid does not trail the strobe by two cycles");

	redirect_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		redirect_i.valid |-> $past(instr_valid_i))
		else $error("redirect valid without a strobe one cycle earlier");

	no_x0_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_i.valid && wb_i.we |-> wb_i.rd != 5'd0)
		else $error("write-back reports a write to x0");

endmodule

bind rv_slice_top rv_slice_top_sva u_sva (
	.clk_i         (clk_i),
	.rst_n_i       (rst_n_i),
	.instr_valid_i (instr_valid_i),
	.redirect_i    (redirect_o),
	.wb_i          (wb_o)
);

// File: tests/rv_slice_top_tb.sv
/* testbench for the rv32i decode/execute slice
   directed tests against an in-order reference register model */
`include "rv_slice_params.svh"

module rv_slice_top_tb;

	timeunit 1ns;
	timeprecision 1ps;

	logic clk;
	logic rst_n;
	logic instr_valid;
	rv_slice_pkg::instr_u instr;
	logic [`XLEN-1:0] pc_in;
	rv_slice_pkg::redirect_t redirect_o;
	rv_slice_pkg::wb_t wb_o;

	int seed = 32'h9c39_c788;
	int neg_count = 0;
	logic [`XLEN-1:0] pc_ctr = 32'h0000_1000;
	logic [`XLEN-1:0] ref_regs [`NUM_REGS];

	rv_slice_pkg::wb_t wb_exp_q [$];
	int wb_due_q [$];
	rv_slice_pkg::redirect_t rdr_exp_q [$];
	int rdr_due_q [$];
	rv_slice_pkg::wb_t exp_wb;
	rv_slice_pkg::redirect_t exp_rdr;

	rv_slice_top rv_slice_top_i (
		.clk_i         (clk),
		.rst_n_i       (rst_n),
		.instr_valid_i (instr_valid),
		.instr_i       (instr),
		.pc_i          (pc_in),
		.redirect_o    (redirect_o),
		.wb_o          (wb_o)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic report_failure();
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
			report_failure();
		end
	endtask

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
	endfunction

	// integer op selected by funct3, alt picks sub / sra
	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: begin
				if (alt)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic model_step(input logic [31:0] w, input logic [31:0] pc);
		logic [6:0] op;
		logic [6:0] f7;
		logic [2:0] f3;
		logic [4:0] rd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_b;
		logic [31:0] imm_j;
		logic [31:0] imm_u;
		logic [31:0] res;
		logic [31:0] tgt;
		logic writes;
		logic jump;
		logic taken;
		logic ill;
		logic ecall;
		logic ebreak;
		logic mis;
		rv_slice_pkg::wb_t wb;
		rv_slice_pkg::redirect_t rdr;
		op = w[6:0];
		rd = w[11:7];
		f3 = w[14:12];
		f7 = w[31:25];
		a = ref_regs[w[19:15]];
		b = ref_regs[w[24:20]];
		imm_i = {{20{w[31]}}, w[31:20]};
		imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		imm_u = {w[31:12], 12'h000};
		res = 32'd0;
		tgt = 32'd0;
		writes = 1'b0;
		jump = 1'b0;
		taken = 1'b0;
		ill = 1'b0;
		ecall = 1'b0;
		ebreak = 1'b0;
		case (op)
			7'h37: begin
				res = imm_u;
				writes = 1'b1;
			end
			7'h17: begin
				res = pc + imm_u;
				writes = 1'b1;
			end
			7'h6f: begin
				res = pc + 32'd4;     // link
				writes = 1'b1;
				jump = 1'b1;
				tgt = pc + imm_j;
			end
			7'h67: begin
				res = pc + 32'd4;
				writes = 1'b1;
				jump = 1'b1;
				tgt = (a + imm_i) & ~32'd1;
				ill = (f3 != 3'd0);
			end
			7'h63: begin
				tgt = pc + imm_b;
				case (f3)
					3'd0: taken = (a == b);
					3'd1: taken = (a != b);
					3'd4: taken = ($signed(a) < $signed(b));
					3'd5: taken = ($signed(a) >= $signed(b));
					3'd6: taken = (a < b);
					3'd7: taken = (a >= b);
					default: ill = 1'b1;
				endcase
			end
			7'h13: begin
				writes = 1'b1;
				if (f3 == 3'd1)
					ill = (f7 != 7'h00);
				else if (f3 == 3'd5)
					ill = !(f7 == 7'h00 || f7 == 7'h20);
				res = alu_ref(f3, (f3 == 3'd5) && f7[5], a, imm_i);
			end
			7'h33: begin
				writes = 1'b1;
				ill = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
				res = alu_ref(f3, f7[5], a, b);
			end
			7'h73: begin
				ecall = (w == 32'h0000_0073);
				ebreak = (w == 32'h0010_0073);
				ill = !(ecall || ebreak);
			end
			default: ill = 1'b1;   // loads, stores and the rest
		endcase
		mis = (jump || taken) && tgt[1];
		wb.valid = 1'b1;
		wb.rd = rd;
		wb.data = res;
		wb.we = writes && !(mis || ecall || ebreak || ill) && (rd != 5'd0);
		wb.exc.misaligned = mis;
		wb.exc.ecall = ecall;
		wb.exc.ebreak = ebreak;
		wb.exc.illegal = ill;
		rdr.valid = jump || taken;
		rdr.target = tgt;
		if (wb.we)
			ref_regs[rd] = res;
		wb_exp_q.push_back(wb);
		wb_due_q.push_back(neg_count + 3);
		rdr_exp_q.push_back(rdr);
		rdr_due_q.push_back(neg_count + 2);
	endtask

	task automatic issue(input logic [31:0] word);
		@(posedge clk);
		instr_valid <= 1'b1;
		instr <= word;
		pc_in <= pc_ctr;
		model_step(word, pc_ctr);
		pc_ctr = pc_ctr + 32'd4;
	endtask

	task automatic wait_drained();
		int cycles;
		cycles = 0;
		@(posedge clk);
		instr_valid <= 1'b0;
		while ((wb_due_q.size() != 0 || rdr_due_q.size() != 0) && cycles < 16) begin
			@(posedge clk);
			cycles++;
		end
		if (wb_due_q.size() != 0 || rdr_due_q.size() != 0) begin
			$display("timeout: outputs still outstanding after %0d cycles", cycles);
			report_failure();
		end
	endtask

	// outputs settle between edges, sample them on the falling edge
	always @(negedge clk) begin
		neg_count = neg_count + 1;
		if (wb_due_q.size() != 0 && wb_due_q[0] == neg_count) begin
			exp_wb = wb_exp_q.pop_front();
			void'(wb_due_q.pop_front());
			if (!wb_o.valid) begin
				$display("write-back missing two cycles after issue at %0t", $time);
				report_failure();
			end else begin
				check_value("wb_o.exc", 32'(wb_o.exc), 32'(exp_wb.exc));
				check_value("wb_o.we", 32'(wb_o.we), 32'(exp_wb.we));
				if (exp_wb.we) begin
					check_value("wb_o.rd", 32'(wb_o.rd), 32'(exp_wb.rd));
					check_value("wb_o.data", wb_o.data, exp_wb.data);
				end
			end
		end else if (wb_o.valid) begin
			$display("write-back raised with nothing issued two cycles before");
			report_failure();
		end
		if (rdr_due_q.size() != 0 && rdr_due_q[0] == neg_count) begin
			exp_rdr = rdr_exp_q.pop_front();
			void'(rdr_due_q.pop_front());
			check_value("redirect_o.valid", 32'(redirect_o.valid), 32'(exp_rdr.valid));
			if (exp_rdr.valid)
				check_value("redirect_o.target", redirect_o.target, exp_rdr.target);
		end else if (redirect_o.valid) begin
			$display("redirect raised with nothing issued the cycle before");
			report_failure();
		end
	end

	task automatic test_alu();
		logic [31:0] v;
		logic [2:0] r_f3 [10];
		logic [6:0] r_f7 [10];
		logic [2:0] i_f3 [6];
		r_f3 = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
		r_f7 = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
		i_f3 = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
		v = $random(seed);
		issue(enc_u(v[31:12], 5'd1, 7'h37));
		issue(enc_i(v[11:0], 5'd1, 3'd0, 5'd1, 7'h13));
		v = $random(seed);
		issue(enc_u(v[31:12], 5'd2, 7'h37));
		issue(enc_i(v[11:0], 5'd2, 3'd0, 5'd2, 7'h13));
		v = $random(seed);
		issue(enc_u(v[31:12], 5'd3, 7'h17));   // auipc
		for (int i = 0; i < 10; i++)
			issue(enc_r(r_f7[i], 5'd2, 5'd1, r_f3[i], 5'(4 + i)));
		for (int i = 0; i < 6; i++) begin
			v = $random(seed);
			issue(enc_i(v[11:0], 5'd1, i_f3[i], 5'(14 + i), 7'h13));
		end
		v = $random(seed);
		issue(enc_i({7'h00, v[4:0]}, 5'd1, 3'd1, 5'd20, 7'h13));
		issue(enc_i({7'h00, v[9:5]}, 5'd1, 3'd5, 5'd21, 7'h13));
		issue(enc_i({7'h20, v[14:10]}, 5'd1, 3'd5, 5'd22, 7'h13));
		wait_drained();
	endtask

	// each source is the previous or second-previous destination
	task automatic test_dependence();
		logic [31:0] r;
		logic [4:0] rd;
		logic [4:0] rd_prev;
		logic [4:0] rd_prev2;
		logic [2:0] f3;
		logic alt;
		rd_prev2 = 5'd1;
		rd_prev = 5'd2;
		for (int i = 0; i < 24; i++) begin
			r = $random(seed);
			rd = 5'(13 + (i % 6));
			f3 = r[3:1];
			alt = r[4] && (f3 == 3'd0 || f3 == 3'd5);
			if (r[5])
				issue(enc_i(r[17:6], r[0] ? rd_prev : rd_prev2, 3'd0, rd, 7'h13));
			else if (r[0])
				issue(enc_r(alt ? 7'h20 : 7'h00, rd_prev2, rd_prev, f3, rd));
			else
				issue(enc_r(alt ? 7'h20 : 7'h00, rd_prev, rd_prev2, f3, rd));
			rd_prev2 = rd_prev;
			rd_prev = rd;
		end
		wait_drained();
	endtask

	task automatic test_branches();
		logic [2:0] ops [6];
		logic [4:0] lhs [5];
		logic [4:0] rhs [5];
		logic [12:0] off;
		ops = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		lhs = '{5'd20, 5'd21, 5'd21, 5'd22, 5'd21};
		rhs = '{5'd21, 5'd20, 5'd21, 5'd21, 5'd22};
		issue(enc_u(20'h80000, 5'd20, 7'h37));   // most negative
		issue(enc_i(12'h001, 5'd0, 3'd0, 5'd21, 7'h13));
		issue(enc_i(12'hfff, 5'd0, 3'd0, 5'd22, 7'h13));
		for (int i = 0; i < 6; i++) begin
			for (int j = 0; j < 5; j++) begin
				off = ((i + j) % 2 == 1) ? 13'h1ff0 : 13'h0010;
				issue(enc_b(off, rhs[j], lhs[j], ops[i]));
			end
		end
		wait_drained();
	endtask

	task automatic test_jumps();
		issue(enc_j(21'h000800, 5'd5));
		issue(enc_i(12'h123, 5'd0, 3'd0, 5'd6, 7'h13));
		issue(enc_i(12'h022, 5'd6, 3'd0, 5'd7, 7'h67));    // bit 0 dropped
		issue(enc_i(12'h055, 5'd0, 3'd0, 5'd8, 7'h13));
		issue(enc_i(12'h01f, 5'd6, 3'd0, 5'd8, 7'h67));    // lands on bit 1
		issue(enc_i(12'h066, 5'd0, 3'd0, 5'd9, 7'h13));
		issue(enc_j(21'h000006, 5'd9));
		issue(enc_j(21'h1ffff0, 5'd10));
		issue(enc_i(12'h000, 5'd8, 3'd0, 5'd11, 7'h13));
		issue(enc_i(12'h000, 5'd9, 3'd0, 5'd12, 7'h13));
		issue(enc_i(12'h000, 5'd5, 3'd0, 5'd13, 7'h13));
		wait_drained();
	endtask

	task automatic test_exceptions();
		issue(enc_i(12'h077, 5'd0, 3'd0, 5'd5, 7'h13));
		issue(32'h0000_0073);
		issue(32'h0010_0073);
		issue(enc_i(12'h000, 5'd1, 3'd2, 5'd5, 7'h03));
		issue(enc_b(13'h0010, 5'd2, 5'd1, 3'd2));
		issue(enc_i(12'h000, 5'd5, 3'd0, 5'd14, 7'h13));
		wait_drained();
	endtask

	task automatic test_x0();
		issue(enc_i(12'h7ff, 5'd0, 3'd0, 5'd0, 7'h13));
		issue(enc_u(20'habcde, 5'd0, 7'h37));
		issue(enc_r(7'h00, 5'd1, 5'd0, 3'd0, 5'd15));
		issue(enc_i(12'h000, 5'd0, 3'd0, 5'd16, 7'h13));
		wait_drained();
	endtask

	initial begin
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		pc_in = '0;
		for (int i = 0; i < `NUM_REGS; i++)
			ref_regs[i] = '0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		test_alu();
		test_dependence();
		test_branches();
		test_jumps();
		test_exceptions();
		test_x0();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: rv_slice_top.f
+incdir+logic
logic/rv_slice_pkg.sv
logic/instr_decoder.sv
logic/register_file.sv
logic/id_stage.sv
logic/ex_stage.sv
logic/rv_slice_top.sv
tests/rv_slice_top_sva.sv
tests/rv_slice_top_tb.sv

// File: Makefile
# Verilator flow for the rv32i decode/execute slice

VERILATOR ?= verilator
TOP ?= rv_slice_top_tb
FILELIST ?= rv_slice_top.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert
FAIL_PATTERN ?= Simulation finished: FAIL
PASS_PATTERN ?= Simulation finished: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_PATTERN)" $(LOG); then \
		echo "result: failing run, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_PATTERN)" $(LOG); then \
		echo "result: run ended without a verdict, see $(LOG)"; exit 1; \
	else \
		echo "result: run passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
